// File: hw/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            ctrl_valid,
    input  mips_pkg::ctrl_t ctrl,
    input  logic [31:0]     rs_data,
    input  logic [31:0]     rt_data,
    input  logic [31:0]     pc,
    output logic [4:0]      rs_addr,
    output logic [4:0]      rt_addr,
    output mips_pkg::exec_t ex
);

    import mips_pkg::*;

    logic [31:0] rs_val, rt_val;
    logic [31:0] imm_ext, op_b;
    logic [4:0]  sh_amt;
    logic [31:0] result;
    logic        cond;
    logic [31:0] cur_pc, pc_plus4;
    logic [31:0] br_target, j_target;
    exec_t       nxt;

    assign rs_addr = ctrl.rs;
    assign rt_addr = ctrl.rt;

    // older instruction commits on this same edge, take its result
    assign rs_val = (ex.valid && ex.reg_write && ex.dest == ctrl.rs && ctrl.rs != 5'd0)
                  ? ex.result : rs_data;
    assign rt_val = (ex.valid && ex.reg_write && ex.dest == ctrl.rt && ctrl.rt != 5'd0)
                  ? ex.result : rt_data;

    // pc of this instruction, pending update included
    assign cur_pc   = ex.valid ? (ex.redirect ? ex.target : pc + 32'd4) : pc;
    assign pc_plus4 = cur_pc + 32'd4;

    assign imm_ext = ctrl.zero_ext ? {16'b0, ctrl.imm16} : {{16{ctrl.imm16[15]}}, ctrl.imm16};
    assign op_b    = ctrl.alu_src ? imm_ext : rt_val;
    assign sh_amt  = ctrl.shift_var ? rs_val[4:0] : ctrl.shamt;

    assign br_target = pc_plus4 + {{14{ctrl.imm16[15]}}, ctrl.imm16, 2'b00};
    assign j_target  = {pc_plus4[31:28], ctrl.target26, 2'b00};

    always_comb
    begin
        result = '0;
        cond   = 1'b0;
        case (ctrl.alu_op)
            ALU_XOR:  result = rs_val ^ op_b;
            ALU_SLL:  result = rt_val << sh_amt;
            ALU_SRL:  result = rt_val >> sh_amt;
            ALU_SRA:  result = $unsigned($signed(rt_val) >>> sh_amt); // sign fill
            ALU_ADD:  result = rs_val + op_b;
            ALU_SUB:  result = rs_val - op_b;
            ALU_OR:   result = rs_val | op_b;
            ALU_NOR:  result = ~(rs_val | op_b);
            ALU_AND:  result = rs_val & op_b;
            ALU_SLT:  result = {31'b0, $signed(rs_val) < $signed(op_b)};
            ALU_LUI:  result = {ctrl.imm16, 16'b0};
            ALU_BEQ:  cond = (rs_val == rt_val);
            ALU_BNE:  cond = (rs_val != rt_val);
            ALU_BLEZ: cond = rs_val[31] || (rs_val == 32'd0);
            ALU_BGTZ: cond = !rs_val[31] && (rs_val != 32'd0);
            ALU_BGEZ: cond = !rs_val[31];
            default:  result = '0; // jr, mul, div produce no value
        endcase
    end

    always_comb
    begin
        nxt           = '0;
        nxt.valid     = ctrl_valid;
        nxt.reg_write = ctrl.reg_write;
        nxt.dest      = ctrl.dst_rd ? ctrl.rd : ctrl.rt;
        nxt.result    = result;
        nxt.illegal   = ctrl.illegal;
        nxt.taken     = ctrl.branch & cond;
        nxt.jump      = ctrl.jump;
        nxt.redirect  = (ctrl.branch & cond) | ctrl.jump;
        if (ctrl.alu_op == ALU_JR)
            nxt.target = rs_val;
        else if (ctrl.jump)
            nxt.target = j_target;
        else
            nxt.target = br_target;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ex <= '0;
        else
            ex <= nxt;
    end

endmodule

`default_nettype wire

// File: hw/mips_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mips_apb_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        issue_valid,
    output logic [31:0] issue_instr,
    output logic        host_we,
    output logic [5:0]  host_addr,
    output logic [31:0] host_wdata,
    input  logic [31:0] rd_data,
    output logic [5:0]  rd_addr,
    input  logic        retire
);

    import mips_pkg::*;

    logic [1:0] inflight; // at most two instructions in the pipe
    logic       access, busy;
    logic       is_reg, is_pc, is_status, is_instr;
    logic       err, needs_idle;
    logic [5:0] index;

    assign access    = psel & penable;
    assign busy      = (inflight != 2'd0);

    // ************************************************************
    // address decode
    // ************************************************************
    assign is_reg    = (paddr[11:7] == REG_BASE[11:7]) && (paddr[1:0] == 2'b00);
    assign is_pc     = (paddr == PC_ADDR);
    assign is_status = (paddr == STATUS_ADDR);
    assign is_instr  = (paddr == INSTR_ADDR);

    assign err        = !(is_reg || is_pc || (is_instr && pwrite) || (is_status && !pwrite));
    assign needs_idle = !err && !is_instr; // reads and host writes wait for empty pipe
    assign index      = is_reg ? {1'b0, paddr[6:2]} : (is_pc ? HOST_PC : HOST_STATUS);

    assign pready  = !(access && needs_idle && busy);
    assign pslverr = access && err;
    assign prdata  = (access && !pwrite && needs_idle && !busy) ? rd_data : '0;

    assign issue_valid = access && pwrite && is_instr;
    assign issue_instr = pwdata;
    assign host_we     = access && pwrite && needs_idle && !busy;
    assign host_addr   = index;
    assign host_wdata  = pwdata;
    assign rd_addr     = index;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            inflight <= 2'd0;
        else
        begin
            case ({issue_valid, retire})
                2'b10:   inflight <= inflight + 2'd1;
                2'b01:   inflight <= inflight - 2'd1;
                default: inflight <= inflight; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  logic [31:0]     issue_instr,
    output logic            ctrl_valid,
    output mips_pkg::ctrl_t ctrl
);

    import mips_pkg::*;

    ctrl_t   dec;
    opcode_e opcode;
    func_e   func;

    assign opcode = opcode_e'(issue_instr[31:26]);
    assign func   = func_e'(issue_instr[5:0]);

    always_comb
    begin
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.rs       = issue_instr[25:21];
        dec.rt       = issue_instr[20:16];
        dec.rd       = issue_instr[15:11];
        dec.shamt    = issue_instr[10:6];
        dec.imm16    = issue_instr[15:0];
        dec.target26 = issue_instr[25:0];

        case (opcode)
            OP_RTYPE:
            begin
                dec.dst_rd    = 1'b1;
                dec.reg_write = 1'b1;
                case (func)
                    F_XOR:         dec.alu_op = ALU_XOR;
                    F_SLL:         dec.alu_op = ALU_SLL;
                    F_SRL:         dec.alu_op = ALU_SRL;
                    F_SRA:         dec.alu_op = ALU_SRA;
                    F_ADD, F_ADDU: dec.alu_op = ALU_ADD; // no overflow trap
                    F_SUB, F_SUBU: dec.alu_op = ALU_SUB;
                    F_OR:          dec.alu_op = ALU_OR;
                    F_NOR:         dec.alu_op = ALU_NOR;
                    F_AND:         dec.alu_op = ALU_AND;
                    F_SLT:         dec.alu_op = ALU_SLT;
                    F_SLLV:
                    begin
                        dec.alu_op    = ALU_SLL;
                        dec.shift_var = 1'b1;
                    end
                    F_SRLV:
                    begin
                        dec.alu_op    = ALU_SRL;
                        dec.shift_var = 1'b1;
                    end
                    F_JR:
                    begin
                        dec.alu_op    = ALU_JR;
                        dec.jump      = 1'b1;
                        dec.reg_write = 1'b0;
                    end
                    F_MULT, F_DIV, F_SYSCALL:
                    begin
                        dec.illegal   = 1'b1; // multi-cycle ops not built
                        dec.reg_write = 1'b0;
                    end
                    default:
                    begin
                        dec.illegal   = 1'b1;
                        dec.reg_write = 1'b0;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: {dec.alu_src, dec.reg_write} = 2'b11;
            OP_ANDI:
            begin
                {dec.alu_src, dec.reg_write, dec.zero_ext} = 3'b111;
                dec.alu_op = ALU_AND;
            end
            OP_XORI:
            begin
                {dec.alu_src, dec.reg_write, dec.zero_ext} = 3'b111;
                dec.alu_op = ALU_XOR;
            end
            OP_ORI:
            begin
                {dec.alu_src, dec.reg_write, dec.zero_ext} = 3'b111;
                dec.alu_op = ALU_OR;
            end
            OP_SLTI:
            begin
                {dec.alu_src, dec.reg_write} = 2'b11;
                dec.alu_op = ALU_SLT;
            end
            OP_LUI:
            begin
                {dec.alu_src, dec.reg_write} = 2'b11;
                dec.alu_op = ALU_LUI;
            end
            OP_BEQ:  {dec.branch, dec.alu_src, dec.alu_op} = {2'b11, ALU_BEQ};
            OP_BNE:  {dec.branch, dec.alu_src, dec.alu_op} = {2'b11, ALU_BNE};
            OP_BLEZ: {dec.branch, dec.alu_src, dec.alu_op} = {2'b11, ALU_BLEZ};
            OP_BGTZ: {dec.branch, dec.alu_src, dec.alu_op} = {2'b11, ALU_BGTZ};
            OP_BGEZ: {dec.branch, dec.alu_src, dec.alu_op} = {2'b11, ALU_BGEZ};
            OP_J, OP_JAL: dec.jump = 1'b1; // jal has no link write
            OP_LW, OP_SW: dec.illegal = 1'b1;
            default:      dec.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end
        else
        begin
            ctrl_valid <= issue_valid;
            ctrl       <= dec;
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import mips_pkg::*;

    logic        issue_valid;
    logic [31:0] issue_instr;
    logic        host_we;
    logic [5:0]  host_addr, rd_addr;
    logic [31:0] host_wdata, rd_data;
    logic        retire;
    logic        ctrl_valid;
    ctrl_t       ctrl;
    exec_t       ex;
    logic [4:0]  rs_addr, rt_addr;
    logic [31:0] rs_data, rt_data, pc;

    mips_apb_regs u_apb (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .issue_valid, .issue_instr,
        .host_we, .host_addr, .host_wdata, .rd_data, .rd_addr, .retire
    );

    mips_decode u_decode (
        .clk, .arst_n, .issue_valid, .issue_instr, .ctrl_valid, .ctrl
    );

    mips_alu u_alu (
        .clk, .arst_n, .ctrl_valid, .ctrl, .rs_data, .rt_data, .pc,
        .rs_addr, .rt_addr, .ex
    );

    mips_writeback u_wb (
        .clk, .arst_n, .ex, .host_we, .host_addr, .host_wdata, .rd_addr, .rd_data,
        .rs_addr, .rt_addr, .rs_data, .rt_data, .pc, .retire
    );

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // ************************************************************
    // instruction encodings
    // ************************************************************
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BGEZ  = 6'b000001,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_BLEZ  = 6'b000110,
        OP_BGTZ  = 6'b000111,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011, // decoded as illegal, no data memory
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL     = 6'b000000,
        F_SRL     = 6'b000010,
        F_SRA     = 6'b000011,
        F_SLLV    = 6'b000100,
        F_SRLV    = 6'b000110,
        F_JR      = 6'b001000,
        F_SYSCALL = 6'b001100,
        F_MULT    = 6'b011000,
        F_DIV     = 6'b011010,
        F_ADD     = 6'b100000,
        F_ADDU    = 6'b100001,
        F_SUB     = 6'b100010,
        F_SUBU    = 6'b100011,
        F_AND     = 6'b100100,
        F_OR      = 6'b100101,
        F_XOR     = 6'b100110,
        F_NOR     = 6'b100111,
        F_SLT     = 6'b101010
    } func_e;

    typedef enum logic [4:0] {
        ALU_XOR  = 5'b00000,
        ALU_SLL  = 5'b00001,
        ALU_SRL  = 5'b00010,
        ALU_SRA  = 5'b00011,
        ALU_ADD  = 5'b00100,
        ALU_SUB  = 5'b00101,
        ALU_MUL  = 5'b00110, // never produced
        ALU_DIV  = 5'b00111, // never produced
        ALU_OR   = 5'b01000,
        ALU_NOR  = 5'b01001,
        ALU_AND  = 5'b01010,
        ALU_SLT  = 5'b01011,
        ALU_JR   = 5'b01100,
        ALU_BEQ  = 5'b01101,
        ALU_BNE  = 5'b01110,
        ALU_BLEZ = 5'b01111,
        ALU_BGTZ = 5'b10000,
        ALU_BGEZ = 5'b10001,
        ALU_LUI  = 5'b10010
    } alu_op_e;

    // ************************************************************
    // apb address map
    // ************************************************************
    localparam logic [11:0] REG_BASE    = 12'h000; // 32 words
    localparam logic [11:0] INSTR_ADDR  = 12'h080;
    localparam logic [11:0] STATUS_ADDR = 12'h084;
    localparam logic [11:0] PC_ADDR     = 12'h088;

    // host port index, 0..31 are the gprs
    localparam logic [5:0] HOST_PC     = 6'd32;
    localparam logic [5:0] HOST_STATUS = 6'd33;

    // ************************************************************
    // stage payloads
    // ************************************************************
    typedef struct packed {
        logic          dst_rd;    // 1 rd, 0 rt
        logic          jump;
        logic          branch;
        logic          alu_src;   // immediate as operand b
        logic          zero_ext;
        logic          shift_var; // shift amount from rs
        logic          reg_write;
        logic          illegal;
        alu_op_e       alu_op;
        logic [4:0]    rs;
        logic [4:0]    rt;
        logic [4:0]    rd;
        logic [4:0]    shamt;
        logic [15:0]   imm16;
        logic [25:0]   target26;
    } ctrl_t;

    typedef struct packed {
        logic          valid;
        logic          reg_write;
        logic [4:0]    dest;
        logic [31:0]   result;
        logic          redirect;
        logic [31:0]   target;
        logic          illegal;
        logic          taken;
        logic          jump;
    } exec_t;

    typedef struct packed {
        logic illegal_seen; // sticky
        logic illegal;
        logic taken;
        logic jump;
    } status_t;

endpackage

`default_nettype wire

// File: hw/mips_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mips_writeback (
    input  logic            clk,
    input  logic            arst_n,
    input  mips_pkg::exec_t ex,
    input  logic            host_we,
    input  logic [5:0]      host_addr,
    input  logic [31:0]     host_wdata,
    input  logic [5:0]      rd_addr,
    output logic [31:0]     rd_data,
    input  logic [4:0]      rs_addr,
    input  logic [4:0]      rt_addr,
    output logic [31:0]     rs_data,
    output logic [31:0]     rt_data,
    output logic [31:0]     pc,
    output logic            retire
);

    import mips_pkg::*;

    logic [31:0] regs [32];
    status_t     status;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            pc     <= '0;
            status <= '0;
        end
        else if (ex.valid)
        begin
            if (ex.reg_write && ex.dest != 5'd0)
                regs[ex.dest] <= ex.result;
            pc     <= ex.redirect ? ex.target : pc + 32'd4;
            status <= '{illegal_seen: status.illegal_seen | ex.illegal,
                        illegal: ex.illegal, taken: ex.taken, jump: ex.jump};
        end
        else if (host_we)
        begin
            if (host_addr == HOST_PC)
                pc <= host_wdata;
            else if (!host_addr[5] && host_addr[4:0] != 5'd0) // r0 stays zero
                regs[host_addr[4:0]] <= host_wdata;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign retire  = ex.valid;

    always_comb
    begin
        if (rd_addr == HOST_PC)
            rd_data = pc;
        else if (rd_addr == HOST_STATUS)
            rd_data = {28'b0, status};
        else
            rd_data = regs[rd_addr[4:0]];
    end

endmodule

`default_nettype wire

// File: mips_exec_top.f
hw/mips_pkg.sv
hw/mips_decode.sv
hw/mips_alu.sv
hw/mips_writeback.sv
hw/mips_apb_regs.sv
hw/mips_exec_top.sv
sim/mips_checker.sv
sim/tb_mips_exec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mips_exec \
    -f mips_exec_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mips_exec)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: sim/mips_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mips_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic [31:0] exp_data,
    input  logic        exp_err,
    output int          errors,
    output int          transfers
);

    localparam int STALL_LIMIT = 16; // back-pressure never lasts past two cycles

    int stall;

    // ************************************************************
    // completed transfers are sampled on the rising edge
    // ************************************************************
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            errors    = 0;
            transfers = 0;
            stall     = 0;
        end
        else if (psel && penable)
        begin
            if (pready)
            begin
                transfers = transfers + 1;
                stall     = 0;
                if (pslverr !== exp_err)
                begin
                    $display("FAILED t=%0t pslverr at 0x%03h: expected %0b, got %0b",
                             $time, paddr, exp_err, pslverr);
                    errors = errors + 1;
                end
                if (!pwrite && prdata !== exp_data)
                begin
                    $display("FAILED t=%0t prdata at 0x%03h: expected %08h, got %08h",
                             $time, paddr, exp_data, prdata);
                    errors = errors + 1;
                end
            end
            else
            begin
                stall = stall + 1;
                if (stall == STALL_LIMIT)
                begin
                    $display("no response: pready held low for %0d cycles at address 0x%03h",
                             STALL_LIMIT, paddr);
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/mips_golden.txt
// columns: op addr data err, op 1 = write, 0 = read, f = end of list
// data is the write data or the expected read data, err is the expected pslverr
1 004 12345678 0
1 008 800000f0 0
1 00c 00000004 0
0 004 12345678 0
1 080 00222026 0 // xor r4, r1, r2
0 010 92345688 0
1 080 00022903 0 // sra r5, r2, 4
0 014 f800000f 0
1 080 00623006 0 // srlv r6, r2, r3
0 018 0800000f 0
1 080 00613804 0 // sllv r7, r1, r3
0 01c 23456780 0
1 080 0041402a 0 // slt r8, r2, r1
0 020 00000001 0
1 080 00234827 0 // nor r9, r1, r3
0 024 edcba983 0
1 080 00235022 0 // sub r10, r1, r3
0 028 12345674 0
1 080 00035a00 0 // sll r11, r3, 8
0 02c 00000400 0
1 080 304cffff 0 // andi r12, r2, 0xffff
0 030 000000f0 0
1 080 340d8001 0 // ori r13, r0, 0x8001
0 034 00008001 0
1 080 382effff 0 // xori r14, r1, 0xffff
0 038 1234a987 0
1 080 206ffff8 0 // addi r15, r3, -8
0 03c fffffffc 0
1 080 2870ffff 0 // slti r16, r3, -1
0 040 00000000 0
1 080 3c11abcd 0 // lui r17, 0xabcd
0 044 abcd0000 0
1 080 24120005 0 // addiu r18 then dependent addu r19, back to back
1 080 02529821 0
0 048 00000005 0
0 04c 0000000a 0
1 088 00001000 0
1 080 10210003 0 // beq taken
0 088 00001010 0
0 084 00000002 0
1 080 14210003 0 // bne not taken
0 088 00001014 0
0 084 00000000 0
1 080 1840fffc 0 // blez taken backwards
0 088 00001008 0
1 080 1c400001 0 // bgtz not taken
0 088 0000100c 0
1 080 04610002 0 // bgez taken
0 088 00001018 0
0 084 00000002 0
1 088 70000010 0
1 080 08000100 0 // j keeps the upper pc bits
0 088 70000400 0
0 084 00000001 0
1 080 00200008 0 // jr r1
0 088 12345678 0
0 084 00000001 0
1 080 8c140000 0 // lw
0 050 00000000 0
0 084 0000000c 0
1 080 ac150000 0 // sw
1 080 fc160000 0 // unknown opcode
0 054 00000000 0
0 058 00000000 0
0 088 12345684 0
0 084 0000000c 0
1 080 24000005 0 // addiu r0
0 000 00000000 0
0 084 00000008 0
1 000 ffffffff 0
0 000 00000000 0
1 080 24170007 0 // host pc write has to wait for this commit
1 088 00000100 0
0 088 00000100 0
0 05c 00000007 0
0 080 00000000 1
1 084 00000005 1
0 0fc 00000000 1
0 002 00000000 1
1 08c 00000001 1
0 100 00000000 1
f 000 00000000 0

// File: sim/tb_mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec;

    localparam int MAX_OPS = 128;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] exp_data;
    logic        exp_err;
    int          chk_errors;
    int          chk_transfers;

    logic [31:0] golden [4*MAX_OPS]; // op, addr, data, err for each line
    int          num_ops;
    int          base;

    mips_exec_top u_dut (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    mips_checker u_chk (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr,
        .exp_data, .exp_err, .errors(chk_errors), .transfers(chk_transfers)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ************************************************************
    // apb master, setup and access phases on the falling edge
    // ************************************************************
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] data, input logic err);
        @(negedge clk);
        psel     = 1'b1;
        penable  = 1'b0;
        pwrite   = write;
        paddr    = addr;
        pwdata   = write ? data : 32'h0;
        exp_data = write ? 32'h0 : data; // prdata only checked on reads
        exp_err  = err;
        @(negedge clk);
        penable  = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
    endtask

    initial
    begin
        wait (num_ops > 0);
        repeat (16 + num_ops * 40) @(posedge clk);
        $display("timeout: transfers still pending after %0d cycles", 16 + num_ops * 40);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        int n;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        exp_data = '0;
        exp_err  = 1'b0;
        arst_n   = 1'b0;

        $readmemh("sim/mips_golden.txt", golden);
        n = 0;
        while (n < MAX_OPS && golden[4 * n] !== 32'hf) // f marks the end
            n++;
        if (n == 0 || n == MAX_OPS)
        begin
            $display("golden file is empty or has no end marker");
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            num_ops = n;
            repeat (16) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;

            for (int i = 0; i < num_ops; i++)
            begin
                base = 4 * i;
                apb_transfer(golden[base][0], golden[base + 1][11:0],
                             golden[base + 2], golden[base + 3][0]);
            end

            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            repeat (2) @(posedge clk);

            $display("transfers %0d of %0d, errors %0d", chk_transfers, num_ops, chk_errors);
            if (chk_errors == 0 && chk_transfers == num_ops)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
